// File: sim.f
source/cmpr_pkg.sv
source/rd_beat_fifo.sv
source/page_size_est.sv
source/zspg_class_table.sv
source/cmpr_mngr.sv
source/cmpr_top.sv
test/tb_mem_model.sv
test/tb_cmpr_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cmpr_top -Mdir obj_dir -f sim.f
./obj_dir/Vtb_cmpr_top | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"

// File: test/tb_cmpr_top.sv
// testbench for the compression manager that applies a table of list walks and checks a model
module tb_cmpr_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS   = 7;
    localparam int NUM_ENTS   = 11;
    // bound for one run with three pages and a stalling page writer
    localparam int RUN_CYCLES = 400;

    typedef struct packed {
        cmpr_pkg::lst_idx_t     tail;
        logic                   err;
        logic [2:0]             pw_delay;
        cmpr_pkg::cmpr_status_e exp_status;
        cmpr_pkg::way_t         exp_way;
        logic [1:0]             exp_pkts;
    } row_t;

    // list entry of one row and the nonzero word count of its page
    typedef struct packed {
        logic [2:0]         row;
        cmpr_pkg::lst_idx_t idx;
        cmpr_pkg::way_t     way;
        cmpr_pkg::lst_idx_t prev;
        logic               valid;
        logic [5:0]         nz;
    } ent_t;

    string names [NUM_ROWS] = '{"list_empty", "two_pages", "no_fit", "too_big",
                                "bus_err", "pw_fast", "pw_delay"};

    // tail, err, writer delay, status, free way, packet count
    row_t rows [NUM_ROWS] = '{
        '{6'd5,  1'b0, 3'd0, cmpr_pkg::LIST_EMPTY, 8'h00, 2'd0},
        '{6'd10, 1'b0, 3'd0, cmpr_pkg::FREED,      8'h21, 2'd2},
        '{6'd20, 1'b0, 3'd0, cmpr_pkg::FREED,      8'h31, 2'd2},
        '{6'd30, 1'b0, 3'd0, cmpr_pkg::TOO_BIG,    8'h00, 2'd0},
        '{6'd31, 1'b1, 3'd0, cmpr_pkg::BUS_ERR,    8'h00, 2'd0},
        '{6'd40, 1'b0, 3'd0, cmpr_pkg::FREED,      8'h51, 2'd2},
        '{6'd50, 1'b0, 3'd5, cmpr_pkg::FREED,      8'h61, 2'd2}
    };

    // row, index, way, prev, valid, nonzero words
    ent_t ents [NUM_ENTS] = '{
        '{3'd0, 6'd5,  8'h00, 6'd0,  1'b0, 6'd0},
        '{3'd1, 6'd10, 8'h20, 6'd9,  1'b1, 6'd10},
        '{3'd1, 6'd9,  8'h21, 6'd8,  1'b1, 6'd12},
        '{3'd2, 6'd20, 8'h30, 6'd19, 1'b1, 6'd14},
        '{3'd2, 6'd19, 8'h31, 6'd18, 1'b1, 6'd9},
        '{3'd3, 6'd30, 8'h40, 6'd29, 1'b1, 6'd32},
        '{3'd4, 6'd31, 8'h41, 6'd30, 1'b1, 6'd5},
        '{3'd5, 6'd40, 8'h50, 6'd39, 1'b1, 6'd7},
        '{3'd5, 6'd39, 8'h51, 6'd38, 1'b1, 6'd6},
        '{3'd6, 6'd50, 8'h60, 6'd49, 1'b1, 6'd28},
        '{3'd6, 6'd49, 8'h61, 6'd48, 1'b1, 6'd3}
    };

    logic                clk_i;
    logic                rst_ni;
    logic                cmpr_req;
    cmpr_pkg::lst_idx_t  ucmp_tail;
    logic                cmpr_ack;
    cmpr_pkg::cmpr_rsp_t cmpr_rsp;
    logic                rd_req;
    cmpr_pkg::rd_cmd_t   rd_cmd;
    logic                rd_ack;
    cmpr_pkg::rd_beat_t  rd_beat;
    logic                pw_req;
    cmpr_pkg::pw_pkt_t   pw_pkt;
    logic                pw_ack;
    cmpr_pkg::tol_upd_t  tol_upd;

    // model copy of the class table that lives across runs like the real one
    bit ref_open [cmpr_pkg::CLASS_COUNT];
    int ref_way  [cmpr_pkg::CLASS_COUNT];
    int ref_fill [cmpr_pkg::CLASS_COUNT];

    cmpr_pkg::pw_pkt_t  ref_pkts [$];
    cmpr_pkg::pw_pkt_t  seen_pkts [$];
    cmpr_pkg::tol_upd_t ref_upds [$];
    cmpr_pkg::tol_upd_t seen_upds [$];

    string cur_name;
    int    errors;
    int    passed;
    int    pw_delay;

    cmpr_top dut_i (.*);

    tb_mem_model mem_i (
        .clk_i, .rd_req, .rd_cmd, .rd_ack, .rd_beat
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // page writer that stalls both the raise and the release of ack by pw_delay cycles
    initial begin
        int wait_cnt;
        pw_ack   = 1'b0;
        wait_cnt = 0;
        forever begin
            @(posedge clk_i);
            #10;
            if (pw_req != pw_ack) begin
                if (wait_cnt == pw_delay) begin
                    if (pw_req) begin
                        seen_pkts.push_back(pw_pkt);
                    end
                    pw_ack   = pw_req;
                    wait_cnt = 0;
                end else begin
                    wait_cnt++;
                end
            end
        end
    end

    // list updates are single-cycle pulses
    initial begin
        forever begin
            @(posedge clk_i);
            #10;
            if (tol_upd.valid) begin
                seen_upds.push_back(tol_upd);
            end
        end
    end

    initial begin
        #((NUM_ROWS * RUN_CYCLES + 10) * 100);
        $display("watchdog expired, the DUT did not finish all runs in time");
        $display("TEST FAILED");
        $finish;
    end

    function automatic int find_ent(input int r, input cmpr_pkg::lst_idx_t idx);
        for (int k = 0; k < NUM_ENTS; k++) begin
            if (ents[k].row == 3'(r) && ents[k].idx == idx) begin
                return k;
            end
        end
        return -1;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    // walks the row's list with the placement rules and queues the expected traffic
    task automatic ref_walk(input int r);
        cmpr_pkg::lst_idx_t idx;
        cmpr_pkg::pw_pkt_t  pkt;
        cmpr_pkg::tol_upd_t upd;
        int                 k;
        int                 size;
        int                 cls;
        bit                 fits;
        bit                 done;
        idx  = rows[r].tail;
        done = 1'b0;
        while (!done) begin
            k = find_ent(r, idx);
            size = (k < 0) ? 0 : int'(ents[k].nz) * cmpr_pkg::BEAT_BYTES;
            if (k < 0 || !ents[k].valid || rows[r].err) begin
                done = 1'b1;
            end else if (size + cmpr_pkg::ZS_MD_SIZE > cmpr_pkg::PAGE_BYTES) begin
                done = 1'b1;
            end else begin
                cls  = (size >= 256) ? 3 : size / 64;
                fits = ref_open[cls] && (ref_fill[cls] + size <= cmpr_pkg::PAGE_BYTES);
                pkt.src_way = ents[k].way;
                pkt.size    = cmpr_pkg::size_t'(size);
                pkt.new_zs  = !fits;
                if (fits) begin
                    pkt.zs_way    = cmpr_pkg::way_t'(ref_way[cls]);
                    pkt.offset    = cmpr_pkg::size_t'(ref_fill[cls]);
                    ref_fill[cls] = ref_fill[cls] + size;
                    done          = 1'b1;
                end else begin
                    pkt.zs_way    = ents[k].way;
                    pkt.offset    = cmpr_pkg::size_t'(cmpr_pkg::ZS_MD_SIZE);
                    ref_open[cls] = 1'b1;
                    ref_way[cls]  = int'(ents[k].way);
                    ref_fill[cls] = cmpr_pkg::ZS_MD_SIZE + size;
                end
                ref_pkts.push_back(pkt);
                upd.valid = 1'b1;
                upd.idx   = idx;
                upd.way   = pkt.zs_way;
                upd.dst   = cmpr_pkg::LST_CMP;
                ref_upds.push_back(upd);
                idx = ents[k].prev;
            end
        end
    endtask

    task automatic run_row(input int r);
        cmpr_pkg::lst_entry_t e;
        cmpr_pkg::cmpr_rsp_t  rsp;
        int                   n;
        for (int i = 0; i < 64; i++) begin
            mem_i.entries[i] = '0;
        end
        for (int k = 0; k < NUM_ENTS; k++) begin
            if (ents[k].row == 3'(r)) begin
                e       = '0;
                e.way   = ents[k].way;
                e.prev  = ents[k].prev;
                e.valid = ents[k].valid;
                e.tag   = cmpr_pkg::LST_UCMP;
                mem_i.entries[ents[k].idx] = e;
                mem_i.page_nz[ents[k].way] = int'(ents[k].nz);
            end
        end
        // the error goes into the tail entry's page
        mem_i.err_en = rows[r].err;
        if (rows[r].err) begin
            mem_i.err_way = ents[find_ent(r, rows[r].tail)].way;
        end
        pw_delay = int'(rows[r].pw_delay);
        ref_pkts.delete();
        seen_pkts.delete();
        ref_upds.delete();
        seen_upds.delete();
        ref_walk(r);
        // four-phase trigger where ack must fall one cycle after req
        ucmp_tail = rows[r].tail;
        cmpr_req  = 1'b1;
        do begin
            @(posedge clk_i);
            #10;
        end while (!cmpr_ack);
        rsp      = cmpr_rsp;
        cmpr_req = 1'b0;
        n        = 0;
        do begin
            @(posedge clk_i);
            #10;
            n++;
        end while (cmpr_ack);
        check_val("status", 64'(rows[r].exp_status), 64'(rsp.status));
        check_val("free way", 64'(rows[r].exp_way), 64'(rsp.free_way));
        check_val("ack release cycles", 64'(1), 64'(n));
        check_val("packet count", 64'(rows[r].exp_pkts), 64'(seen_pkts.size()));
        for (int i = 0; i < ref_pkts.size() && i < seen_pkts.size(); i++) begin
            check_val($sformatf("packet %0d", i), 64'(ref_pkts[i]), 64'(seen_pkts[i]));
        end
        check_val("list update count", 64'(ref_upds.size()), 64'(seen_upds.size()));
        for (int i = 0; i < ref_upds.size() && i < seen_upds.size(); i++) begin
            check_val($sformatf("list update %0d", i), 64'(ref_upds[i]), 64'(seen_upds[i]));
        end
    endtask

    initial begin
        int errs_before;
        errors    = 0;
        passed    = 0;
        pw_delay  = 0;
        cmpr_req  = 1'b0;
        ucmp_tail = '0;
        rst_ni    = 1'b0;
        repeat (3) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #10;
        // idle outputs after reset belong to the first run
        cur_name = names[0];
        check_val("cmpr_ack after reset", 64'(0), 64'(cmpr_ack));
        check_val("rd_req after reset", 64'(0), 64'(rd_req));
        check_val("pw_req after reset", 64'(0), 64'(pw_req));
        check_val("tol_upd valid after reset", 64'(0), 64'(tol_upd.valid));
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_name    = names[r];
            errs_before = (r == 0) ? 0 : errors;
            run_row(r);
            if (errors == errs_before) begin
                passed++;
                $display("test %s: ok", cur_name);
            end else begin
                $display("test %s: %0d mismatches", cur_name, errors - errs_before);
            end
        end
        $display("%0d tests run, %0d passed, %0d checks failed", NUM_ROWS, passed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: test/tb_mem_model.sv
// testbench memory responder, serves list entries and generated pages, can inject an error beat
module tb_mem_model (
    input  logic               clk_i,
    input  logic               rd_req,
    input  cmpr_pkg::rd_cmd_t  rd_cmd,
    output logic               rd_ack,
    output cmpr_pkg::rd_beat_t rd_beat
);
    timeunit 1ns;
    timeprecision 1ps;

    // beat of the page that carries the injected error, lands in the second burst
    localparam int ERR_BEAT = 12;

    // list memory and per-way nonzero word counts, written by the test before each trigger
    cmpr_pkg::lst_entry_t entries [64];
    int                   page_nz [256];
    logic                 err_en;
    cmpr_pkg::way_t       err_way;

    logic [63:0]          rng = 64'd69;
    cmpr_pkg::rd_cmd_t    cmd;

    // 64-bit xorshift, never returns zero from a nonzero state
    function automatic logic [63:0] xorshift64(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    // one beat per cycle, last flag on the final beat
    task automatic stream_beats();
        int             beat;
        cmpr_pkg::way_t way;
        way = cmd.addr[15:8];
        for (int i = 0; i < int'(cmd.beats); i++) begin
            rd_beat       = '0;
            rd_beat.valid = 1'b1;
            rd_beat.last  = (i == int'(cmd.beats) - 1);
            if (cmd.addr >= cmpr_pkg::LST_BASE) begin
                // list area, one entry per beat
                rd_beat.data.entry = entries[6'((cmd.addr - cmpr_pkg::LST_BASE) >> 3)];
            end else begin
                beat = int'(cmd.addr[7:3]) + i;
                // odd stride spreads the nonzero words over the whole page
                if ((beat * 5) % 32 < page_nz[way]) begin
                    rng              = xorshift64(rng);
                    rd_beat.data.raw = rng;
                end
                rd_beat.err = err_en && (way == err_way) && (beat == ERR_BEAT);
            end
            @(posedge clk_i);
            #10;
        end
        rd_beat = '0;
    endtask

    initial begin
        rd_ack  = 1'b0;
        rd_beat = '0;
        err_en  = 1'b0;
        err_way = '0;
        forever begin
            @(posedge clk_i);
            #10;
            if (rd_req && !rd_ack) begin
                cmd    = rd_cmd;
                rd_ack = 1'b1;
            end else if (!rd_req && rd_ack) begin
                // beats follow once the request has been released
                rd_ack = 1'b0;
                stream_beats();
            end
        end
    end

endmodule

// File: source/cmpr_top.sv
// top level of the compression manager, ties the FIFO, compressor, class table and FSM together
module cmpr_top (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                cmpr_req,
    input  cmpr_pkg::lst_idx_t  ucmp_tail,
    output logic                cmpr_ack,
    output cmpr_pkg::cmpr_rsp_t cmpr_rsp,
    output logic                rd_req,
    output cmpr_pkg::rd_cmd_t   rd_cmd,
    input  logic                rd_ack,
    input  cmpr_pkg::rd_beat_t  rd_beat,
    output logic                pw_req,
    output cmpr_pkg::pw_pkt_t   pw_pkt,
    input  logic                pw_ack,
    output cmpr_pkg::tol_upd_t  tol_upd
);

    // FIFO to compressor path
    logic            fifo_push;
    logic            fifo_pop;
    logic            fifo_empty;
    logic [63:0]     fifo_data;
    logic [4:0]      fifo_level;
    logic            page_start;
    cmpr_pkg::size_t comp_size;
    logic            size_valid;

    // class table lookup and update
    logic [1:0]      class_idx;
    logic            zs_open;
    cmpr_pkg::way_t  zs_way;
    cmpr_pkg::size_t zs_fill;
    logic            set_new;
    cmpr_pkg::way_t  new_way;
    cmpr_pkg::size_t new_fill;
    logic            add_fill;
    cmpr_pkg::size_t add_size;

    rd_beat_fifo fifo_i (
        .clk_i, .rst_ni,
        .push(fifo_push), .push_data(rd_beat.data.raw),
        .pop(fifo_pop), .pop_data(fifo_data), .empty(fifo_empty),
        .level(fifo_level), .flush(page_start)
    );

    page_size_est est_i (
        .clk_i, .rst_ni, .page_start,
        .fifo_empty, .fifo_data, .pop(fifo_pop),
        .comp_size, .size_valid
    );

    zspg_class_table table_i (
        .clk_i, .rst_ni, .class_idx,
        .open(zs_open), .zs_way, .fill(zs_fill),
        .set_new, .new_way, .new_fill, .add_fill, .add_size
    );

    cmpr_mngr mngr_i (
        .clk_i, .rst_ni,
        .cmpr_req, .ucmp_tail, .cmpr_ack, .cmpr_rsp,
        .rd_req, .rd_cmd, .rd_ack, .rd_beat, .fifo_push, .fifo_level,
        .page_start, .comp_size, .size_valid,
        .class_idx, .open(zs_open), .zs_way, .fill(zs_fill),
        .set_new, .new_way, .new_fill, .add_fill, .add_size,
        .pw_req, .pw_pkt, .pw_ack, .tol_upd
    );

endmodule

// File: source/cmpr_mngr.sv
// control FSM that walks the uncompressed list, sizes pages, places them and reports the run result
module cmpr_mngr (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 cmpr_req,
    input  cmpr_pkg::lst_idx_t   ucmp_tail,
    output logic                 cmpr_ack,
    output cmpr_pkg::cmpr_rsp_t  cmpr_rsp,
    output logic                 rd_req,
    output cmpr_pkg::rd_cmd_t    rd_cmd,
    input  logic                 rd_ack,
    input  cmpr_pkg::rd_beat_t   rd_beat,
    output logic                 fifo_push,
    input  logic [4:0]           fifo_level,
    output logic                 page_start,
    input  cmpr_pkg::size_t      comp_size,
    input  logic                 size_valid,
    output logic [1:0]           class_idx,
    input  logic                 open,
    input  cmpr_pkg::way_t       zs_way,
    input  cmpr_pkg::size_t      fill,
    output logic                 set_new,
    output cmpr_pkg::way_t       new_way,
    output cmpr_pkg::size_t      new_fill,
    output logic                 add_fill,
    output cmpr_pkg::size_t      add_size,
    output logic                 pw_req,
    output cmpr_pkg::pw_pkt_t    pw_pkt,
    input  logic                 pw_ack,
    output cmpr_pkg::tol_upd_t   tol_upd
);

    typedef enum logic [3:0] {
        IDLE, READ_ENTRY, WAIT_ENTRY, DECODE_ENTRY, BURST_READ,
        COMP_WAIT, PLACE, PW_HANDSHAKE, LIST_UPDATE, RESPOND
    } state_e;

    state_e                 state;
    cmpr_pkg::lst_idx_t     cur_idx;
    cmpr_pkg::lst_entry_t   entry;
    cmpr_pkg::size_t        size_r;
    // bursts acked for this page and beats still owed by memory
    logic [2:0]             bursts;
    logic [4:0]             beats_out;
    logic                   err_seen;
    logic                   pw_sent;
    logic                   room;
    logic                   fits;
    logic [9:0]             fill_sum;

    // class from the latched size, anything at 256 and up lands in the top class
    assign class_idx = size_r[8] ? 2'd3 : size_r[7:6];
    assign fill_sum  = 10'(fill) + 10'(size_r);
    assign fits      = open && (fill_sum <= 10'(cmpr_pkg::PAGE_BYTES));

    // table writes happen in the single PLACE cycle
    assign set_new  = (state == PLACE) && !fits;
    assign add_fill = (state == PLACE) && fits;
    assign new_way  = entry.way;
    assign new_fill = cmpr_pkg::size_t'(cmpr_pkg::ZS_MD_SIZE) + size_r;
    assign add_size = size_r;

    // clear FIFO and compressor as the page walk starts
    assign page_start = (state == DECODE_ENTRY) && entry.valid;
    // page beats go straight into the FIFO
    assign fifo_push  = (state == BURST_READ) && rd_beat.valid;

    // never ask for more beats than the FIFO can still take
    assign room = (6'(fifo_level) + 6'(beats_out))
                  <= 6'(cmpr_pkg::FIFO_DEPTH - cmpr_pkg::BURST_BEATS);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state     <= IDLE;
            cur_idx   <= '0;
            entry     <= '0;
            size_r    <= '0;
            bursts    <= '0;
            beats_out <= '0;
            err_seen  <= 1'b0;
            pw_sent   <= 1'b0;
            cmpr_ack  <= 1'b0;
            cmpr_rsp  <= '0;
            rd_req    <= 1'b0;
            rd_cmd    <= '0;
            pw_req    <= 1'b0;
            pw_pkt    <= '0;
            tol_upd   <= '0;
        end else begin
            tol_upd.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmpr_req) begin
                        cur_idx <= ucmp_tail;
                        state   <= READ_ENTRY;
                    end
                end
                READ_ENTRY: begin
                    // four-phase read of a single list entry beat
                    if (rd_req && rd_ack) begin
                        rd_req <= 1'b0;
                        state  <= WAIT_ENTRY;
                    end else if (!rd_req && !rd_ack) begin
                        rd_req       <= 1'b1;
                        rd_cmd.addr  <= cmpr_pkg::LST_BASE + 16'({cur_idx, 3'b000});
                        rd_cmd.beats <= 6'd1;
                    end
                end
                WAIT_ENTRY: begin
                    if (rd_beat.valid) begin
                        entry <= rd_beat.data.entry;
                        if (rd_beat.err) begin
                            cmpr_ack <= 1'b1;
                            cmpr_rsp <= '{status: cmpr_pkg::BUS_ERR, free_way: '0};
                            state    <= RESPOND;
                        end else begin
                            state <= DECODE_ENTRY;
                        end
                    end
                end
                DECODE_ENTRY: begin
                    if (!entry.valid) begin
                        // walked off the end of the uncompressed list
                        cmpr_ack <= 1'b1;
                        cmpr_rsp <= '{status: cmpr_pkg::LIST_EMPTY, free_way: '0};
                        state    <= RESPOND;
                    end else begin
                        bursts    <= '0;
                        beats_out <= '0;
                        err_seen  <= 1'b0;
                        state     <= BURST_READ;
                    end
                end
                BURST_READ: begin
                    if (rd_req && rd_ack) begin
                        rd_req <= 1'b0;
                        bursts <= bursts + 3'd1;
                    end else if (!rd_req && !rd_ack && !err_seen && room
                                 && bursts != 3'(cmpr_pkg::PAGE_BEATS / cmpr_pkg::BURST_BEATS)) begin
                        rd_req       <= 1'b1;
                        rd_cmd.addr  <= 16'(entry.way) * 16'(cmpr_pkg::PAGE_BYTES)
                                        + 16'(bursts) * 16'(cmpr_pkg::BURST_BEATS * cmpr_pkg::BEAT_BYTES);
                        rd_cmd.beats <= 6'(cmpr_pkg::BURST_BEATS);
                    end
                    // acked burst adds its beats, each arriving beat retires one
                    beats_out <= beats_out
                                 + ((rd_req && rd_ack) ? 5'(cmpr_pkg::BURST_BEATS) : 5'd0)
                                 - 5'(rd_beat.valid);
                    if (rd_beat.valid && rd_beat.err) begin
                        err_seen <= 1'b1;
                    end
                    // leave only with the read channel quiet
                    if (!rd_req && beats_out == 5'd0) begin
                        if (err_seen) begin
                            cmpr_ack <= 1'b1;
                            cmpr_rsp <= '{status: cmpr_pkg::BUS_ERR, free_way: '0};
                            state    <= RESPOND;
                        end else if (bursts == 3'(cmpr_pkg::PAGE_BEATS / cmpr_pkg::BURST_BEATS)) begin
                            state <= COMP_WAIT;
                        end
                    end
                end
                COMP_WAIT: begin
                    if (size_valid) begin
                        size_r <= comp_size;
                        // page plus zspage header must fit in one way
                        if (10'(comp_size) + 10'(cmpr_pkg::ZS_MD_SIZE)
                            > 10'(cmpr_pkg::PAGE_BYTES)) begin
                            cmpr_ack <= 1'b1;
                            cmpr_rsp <= '{status: cmpr_pkg::TOO_BIG, free_way: '0};
                            state    <= RESPOND;
                        end else begin
                            state <= PLACE;
                        end
                    end
                end
                PLACE: begin
                    pw_pkt.src_way <= entry.way;
                    pw_pkt.size    <= size_r;
                    pw_pkt.new_zs  <= !fits;
                    if (fits) begin
                        // migrate into the open zspage of this class
                        pw_pkt.zs_way <= zs_way;
                        pw_pkt.offset <= fill;
                    end else begin
                        // this page's own way starts a fresh zspage
                        pw_pkt.zs_way <= entry.way;
                        pw_pkt.offset <= cmpr_pkg::size_t'(cmpr_pkg::ZS_MD_SIZE);
                    end
                    pw_sent <= 1'b0;
                    state   <= PW_HANDSHAKE;
                end
                PW_HANDSHAKE: begin
                    // page writer holds us off by keeping ack high
                    if (pw_req && pw_ack) begin
                        pw_req  <= 1'b0;
                        pw_sent <= 1'b1;
                    end else if (!pw_req && !pw_ack && !pw_sent) begin
                        pw_req <= 1'b1;
                    end else if (pw_sent && !pw_ack) begin
                        state <= LIST_UPDATE;
                    end
                end
                LIST_UPDATE: begin
                    tol_upd <= '{valid: 1'b1, idx: cur_idx, way: pw_pkt.zs_way,
                                 dst: cmpr_pkg::LST_CMP};
                    if (pw_pkt.new_zs) begin
                        // no way freed yet, go on with the older entry
                        cur_idx <= entry.prev;
                        state   <= READ_ENTRY;
                    end else begin
                        cmpr_ack <= 1'b1;
                        cmpr_rsp <= '{status: cmpr_pkg::FREED, free_way: entry.way};
                        state    <= RESPOND;
                    end
                end
                RESPOND: begin
                    // ack stays up until the requester lets go
                    if (!cmpr_req) begin
                        cmpr_ack <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: source/zspg_class_table.sv
// table of under-construction zspages with one slot per size class for the manager to read and update
module zspg_class_table (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [1:0]      class_idx,
    output logic            open,
    output cmpr_pkg::way_t  zs_way,
    output cmpr_pkg::size_t fill,
    input  logic            set_new,
    input  cmpr_pkg::way_t  new_way,
    input  cmpr_pkg::size_t new_fill,
    input  logic            add_fill,
    input  cmpr_pkg::size_t add_size
);

    // set while a class has an open zspage
    logic [cmpr_pkg::CLASS_COUNT-1:0] slot_vld;
    // zspage way and next free byte inside it
    cmpr_pkg::way_t  slot_way  [cmpr_pkg::CLASS_COUNT];
    cmpr_pkg::size_t slot_fill [cmpr_pkg::CLASS_COUNT];

    // lookup is purely combinational on the class
    assign open   = slot_vld[class_idx];
    assign zs_way = slot_way[class_idx];
    assign fill   = slot_fill[class_idx];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            slot_vld <= '0;
        end else if (set_new) begin
            slot_vld[class_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_new) begin
            // the old zspage of this class is closed by overwriting it
            slot_way[class_idx]  <= new_way;
            slot_fill[class_idx] <= new_fill;
        end else if (add_fill) begin
            // migrated page now occupies the next bytes
            slot_fill[class_idx] <= slot_fill[class_idx] + add_size;
        end
    end

endmodule

// File: source/page_size_est.sv
// zero-word compressor, drains one page of beats from the FIFO and reports its packed size
module page_size_est (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            page_start,
    input  logic            fifo_empty,
    input  logic [63:0]     fifo_data,
    output logic            pop,
    output cmpr_pkg::size_t comp_size,
    output logic            size_valid
);

    // beats taken so far and how many of them carry data
    logic [5:0] beat_cnt;
    logic [5:0] nz_cnt;

    // stop taking beats once the page is complete
    assign pop = !fifo_empty && !page_start && (beat_cnt != 6'(cmpr_pkg::PAGE_BEATS));

    // every nonzero word costs one full beat
    assign comp_size = cmpr_pkg::size_t'(nz_cnt) * cmpr_pkg::size_t'(cmpr_pkg::BEAT_BYTES);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_cnt   <= '0;
            nz_cnt     <= '0;
            size_valid <= 1'b0;
        end else if (page_start) begin
            beat_cnt   <= '0;
            nz_cnt     <= '0;
            size_valid <= 1'b0;
        end else begin
            // one cycle pulse after the last beat of the page
            size_valid <= pop && (beat_cnt == 6'(cmpr_pkg::PAGE_BEATS - 1));
            if (pop) begin
                beat_cnt <= beat_cnt + 6'd1;
                if (fifo_data != 64'd0) begin
                    nz_cnt <= nz_cnt + 6'd1;
                end
            end
        end
    end

endmodule

// File: source/rd_beat_fifo.sv
// circular beat buffer between the memory read stream and the page compressor
module rd_beat_fifo (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        push,
    input  logic [63:0] push_data,
    input  logic        pop,
    output logic [63:0] pop_data,
    output logic        empty,
    output logic [4:0]  level,
    input  logic        flush
);

    // beat storage
    logic [63:0] mem [cmpr_pkg::FIFO_DEPTH];

    // pointers carry one extra bit so full and empty differ
    logic [4:0] wr_ptr;
    logic [4:0] rd_ptr;

    assign level    = wr_ptr - rd_ptr;
    assign empty    = (level == 5'd0);
    assign pop_data = mem[rd_ptr[3:0]];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr[3:0]] <= push_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            // a new page starts from an empty buffer
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 5'd1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 5'd1;
            end
        end
    end

endmodule

// File: source/cmpr_pkg.sv
// shared sizes, list and zspage types, memory beat union and run result for the compression manager
package cmpr_pkg;

    // page geometry, shrunk so one page is 32 beats
    localparam int PAGE_BYTES  = 256;
    localparam int BEAT_BYTES  = 8;
    localparam int PAGE_BEATS  = 32;
    localparam int BURST_BEATS = 8;
    localparam int FIFO_DEPTH  = 16;
    // metadata header at the start of every zspage
    localparam int ZS_MD_SIZE  = 8;
    localparam int CLASS_COUNT = 4;
    // byte address of list entry 0, entries are one beat apart
    localparam logic [15:0] LST_BASE = 16'hFE00;

    typedef logic [7:0] way_t;
    typedef logic [5:0] lst_idx_t;
    typedef logic [8:0] size_t;

    // which list an entry sits on
    typedef enum logic {
        LST_UCMP = 1'b0,
        LST_CMP  = 1'b1
    } lst_tag_e;

    // one list entry, exactly one memory beat wide
    typedef struct packed {
        logic [47:0] pad;
        lst_tag_e    tag;
        logic        valid;
        lst_idx_t    prev;
        way_t        way;
    } lst_entry_t;

    // the same beat is a list entry or raw page data depending on the read
    typedef union packed {
        lst_entry_t  entry;
        logic [63:0] raw;
    } mem_beat_u;

    typedef struct packed {
        logic [15:0] addr;
        logic [5:0]  beats;
    } rd_cmd_t;

    typedef struct packed {
        logic      valid;
        mem_beat_u data;
        logic      last;
        logic      err;
    } rd_beat_t;

    // placement packet to the external page writer
    typedef struct packed {
        way_t  src_way;
        way_t  zs_way;
        size_t offset;
        size_t size;
        logic  new_zs;
    } pw_pkt_t;

    typedef struct packed {
        logic     valid;
        lst_idx_t idx;
        way_t     way;
        lst_tag_e dst;
    } tol_upd_t;

    typedef enum logic [1:0] {
        FREED      = 2'd0,
        LIST_EMPTY = 2'd1,
        TOO_BIG    = 2'd2,
        BUS_ERR    = 2'd3
    } cmpr_status_e;

    typedef struct packed {
        cmpr_status_e status;
        way_t         free_way;
    } cmpr_rsp_t;

endpackage
